//--- design/ble_link_top.sv
`default_nettype none

module ble_link_top (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic [15:0] feature_data,
  input  logic        feature_valid,
  output logic        feature_ready,
  input  logic        uart_rx_in,
  input  logic        uart_cts_in,
  output logic        uart_tx_out,
  output logic [15:0] param_data,
  output logic [7:0]  param_addr,
  output logic        param_valid
);

  logic [15:0] fifo_data;
  logic        fifo_valid;
  logic        fifo_ready;
  logic        uart_tick;

  uart_byte_if link ();

  // Buffers feature words while the link is slow or held off
  feature_fifo fifo_inst (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .in_data   (feature_data),
    .in_valid  (feature_valid),
    .in_ready  (feature_ready),
    .out_data  (fifo_data),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  uart_tick_generator tick_inst (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .tick   (uart_tick)
  );

  uart_tx uart_tx_inst (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .tick   (uart_tick),
    .link   (link.tx),
    .tx     (uart_tx_out)
  );

  uart_rx uart_rx_inst (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .tick   (uart_tick),
    .rx     (uart_rx_in),
    .link   (link.rx)
  );

  bluetooth ctrl_inst (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .fifo_data   (fifo_data),
    .fifo_valid  (fifo_valid),
    .fifo_ready  (fifo_ready),
    .cts         (uart_cts_in),
    .link        (link.ctrl),
    .param_data  (param_data),
    .param_addr  (param_addr),
    .param_valid (param_valid)
  );

endmodule

`default_nettype wire

//--- design/ble_pkg.sv
`default_nettype none

package ble_pkg;

  ////////////////////////////////////////////////////////////
  // Link rates
  ////////////////////////////////////////////////////////////

  localparam int unsigned clk_hz      = 98_304_000;
  localparam int unsigned baudrate_hz = 1_536_000;
  localparam int unsigned sample_rate = 16;

  // Clocks per oversampling tick, 4 at these rates
  localparam int unsigned tick_div = clk_hz / (baudrate_hz * sample_rate);

  ////////////////////////////////////////////////////////////
  // Feature FIFO
  ////////////////////////////////////////////////////////////

  localparam int unsigned fifo_depth  = 256;
  localparam int unsigned fifo_addr_w = 8;

  ////////////////////////////////////////////////////////////
  // State encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {TX_IDLE, TX_LOW, TX_WAIT_LOW, TX_HIGH, TX_WAIT_HIGH} tx_state_t;
  typedef enum logic {RX_LOW, RX_HIGH} rx_state_t;
  typedef enum logic [1:0] {U_IDLE, U_START, U_DATA, U_STOP} uart_state_t;

endpackage

`default_nettype wire

//--- design/bluetooth.sv
`default_nettype none

module bluetooth (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic [15:0] fifo_data,
  input  logic        fifo_valid,
  output logic        fifo_ready,
  input  logic        cts,
  uart_byte_if.ctrl   link,
  output logic [15:0] param_data,
  output logic [7:0]  param_addr,
  output logic        param_valid
);

  import ble_pkg::*;

  tx_state_t  tx_state;
  rx_state_t  rx_state;
  logic [7:0] byte_out;
  logic [7:0] byte_hi;
  logic [7:0] param_lo;
  logic       send_ok;

  ////////////////////////////////////////////////////////////
  // Transmit: one feature word as two bytes
  ////////////////////////////////////////////////////////////

  assign fifo_ready = (tx_state == TX_IDLE);

  // Clear-to-send only gates the start of a byte
  assign send_ok       = !cts && !link.tx_busy;
  assign link.tx_start = (tx_state == TX_LOW || tx_state == TX_HIGH) && send_ok;
  assign link.tx_data  = byte_out;

  always_ff @(posedge clk_in) begin
    if (tx_state == TX_IDLE && fifo_valid) begin
      byte_out <= fifo_data[7:0];
      byte_hi  <= fifo_data[15:8];
    end else if (tx_state == TX_WAIT_LOW && link.tx_done) begin
      byte_out <= byte_hi;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      tx_state <= TX_IDLE;
    end else begin
      case (tx_state)
        TX_IDLE:      if (fifo_valid) tx_state <= TX_LOW;
        TX_LOW:       if (send_ok) tx_state <= TX_WAIT_LOW;
        TX_WAIT_LOW:  if (link.tx_done) tx_state <= TX_HIGH;
        TX_HIGH:      if (send_ok) tx_state <= TX_WAIT_HIGH;
        TX_WAIT_HIGH: if (link.tx_done) tx_state <= TX_IDLE;
        default:      tx_state <= TX_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive: byte pairs into parameter words
  ////////////////////////////////////////////////////////////

  // High byte completes the word in the cycle it arrives
  assign param_valid = (rx_state == RX_HIGH) && link.rx_done;
  assign param_data  = {link.rx_data, param_lo};

  always_ff @(posedge clk_in) begin
    if (rx_state == RX_LOW && link.rx_done) begin
      param_lo <= link.rx_data;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rx_state   <= RX_LOW;
      param_addr <= '0;
    end else if (link.rx_done) begin
      case (rx_state)
        RX_LOW: begin
          rx_state <= RX_HIGH;
        end
        RX_HIGH: begin
          rx_state   <= RX_LOW;
          param_addr <= param_addr + 1'b1;  // wraps at 256
        end
        default: rx_state <= RX_LOW;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/feature_fifo.sv
`default_nettype none

module feature_fifo (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic [15:0] in_data,
  input  logic        in_valid,
  output logic        in_ready,
  output logic [15:0] out_data,
  output logic        out_valid,
  input  logic        out_ready
);

  import ble_pkg::*;

  logic [15:0]            mem [fifo_depth];
  logic [fifo_addr_w-1:0] wr_ptr;
  logic [fifo_addr_w-1:0] rd_ptr;
  logic [fifo_addr_w:0]   count;
  logic                   push;
  logic                   pop;

  assign in_ready  = (int'(count) != fifo_depth);
  assign out_valid = (count != '0);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // Oldest word is always at the head, no read latency
  assign out_data = mem[rd_ptr];

  always_ff @(posedge clk_in) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/uart_byte_if.sv
`default_nettype none

// Byte-level link between the controller and the two UART engines
interface uart_byte_if;

  logic [7:0] tx_data;
  logic       tx_start;
  logic       tx_busy;
  logic       tx_done;
  logic [7:0] rx_data;
  logic       rx_done;

  modport ctrl (
    output tx_data, tx_start,
    input  tx_busy, tx_done, rx_data, rx_done
  );

  modport tx (
    input  tx_data, tx_start,
    output tx_busy, tx_done
  );

  modport rx (
    output rx_data, rx_done
  );

endinterface

`default_nettype wire

//--- design/uart_rx.sv
`default_nettype none

module uart_rx (
  input  logic  clk_in,
  input  logic  rst_in,
  input  logic  tick,
  input  logic  rx,
  uart_byte_if.rx link
);

  import ble_pkg::*;

  uart_state_t                    state;
  logic [7:0]                     shift;
  logic [$clog2(sample_rate)-1:0] tick_cnt;
  logic [2:0]                     bit_idx;
  logic                           rx_meta;
  logic                           rx_sync;
  logic                           rx_prev;
  logic                           done;
  logic                           fall;
  logic                           half_bit;
  logic                           bit_end;

  assign link.rx_data = shift;
  assign link.rx_done = done;

  assign fall     = rx_prev && !rx_sync;
  assign half_bit = tick && (int'(tick_cnt) == sample_rate / 2 - 1);
  assign bit_end  = tick && (int'(tick_cnt) == sample_rate - 1);

  // Line rests high, so the synchronizer starts there too
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk_in) begin
    if (state == U_DATA && bit_end) begin
      shift <= {rx_sync, shift[7:1]};
    end
  end

  ////////////////////////////////////////////////////////////
  // Frame recovery
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state    <= U_IDLE;
      tick_cnt <= '0;
      bit_idx  <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        U_IDLE: begin
          if (fall) begin
            state <= U_START;
          end
        end
        U_START: begin
          // From mid start bit on, every full bit lands mid-bit
          if (half_bit) begin
            tick_cnt <= '0;
            bit_idx  <= '0;
            state    <= rx_sync ? U_IDLE : U_DATA;
          end else if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        U_DATA: begin
          if (tick) begin
            tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
          end
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= U_STOP;
            end
          end
        end
        U_STOP: begin
          if (tick) begin
            tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
          end
          // Low stop bit drops the byte
          if (bit_end) begin
            state <= U_IDLE;
            done  <= rx_sync;
          end
        end
        default: state <= U_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/uart_tick_generator.sv
`default_nettype none

module uart_tick_generator (
  input  logic clk_in,
  input  logic rst_in,
  output logic tick
);

  import ble_pkg::*;

  logic [$clog2(tick_div)-1:0] count;
  logic                        wrap;

  assign wrap = (int'(count) == tick_div - 1);

  // One tick per sample_rate-th of a bit
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      count <= '0;
      tick  <= 1'b0;
    end else begin
      tick <= wrap;
      if (wrap) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/uart_tx.sv
`default_nettype none

module uart_tx (
  input  logic  clk_in,
  input  logic  rst_in,
  input  logic  tick,
  uart_byte_if.tx link,
  output logic  tx
);

  import ble_pkg::*;

  uart_state_t                    state;
  logic [7:0]                     shift;
  logic [$clog2(sample_rate)-1:0] tick_cnt;
  logic [2:0]                     bit_idx;
  logic                           busy;
  logic                           done;
  logic                           accept;
  logic                           bit_end;

  assign link.tx_busy = busy;
  assign link.tx_done = done;

  assign accept  = link.tx_start && !busy;
  assign bit_end = tick && (int'(tick_cnt) == sample_rate - 1);

  // Byte to send, shifted out LSB first
  always_ff @(posedge clk_in) begin
    if (accept) begin
      shift <= link.tx_data;
    end else if (state == U_DATA && bit_end) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

  ////////////////////////////////////////////////////////////
  // Frame sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state    <= U_IDLE;
      tick_cnt <= '0;
      bit_idx  <= '0;
      busy     <= 1'b0;
      done     <= 1'b0;
      tx       <= 1'b1;
    end else begin
      done <= 1'b0;
      if (state != U_IDLE && tick) begin
        tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
      end
      case (state)
        U_IDLE: begin
          // Busy but idle means a byte is waiting for the next tick
          if (accept) begin
            busy <= 1'b1;
          end else if (busy && tick) begin
            state <= U_START;
            tx    <= 1'b0;
          end
        end
        U_START: begin
          if (bit_end) begin
            state   <= U_DATA;
            bit_idx <= '0;
            tx      <= shift[0];
          end
        end
        U_DATA: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= U_STOP;
              tx    <= 1'b1;
            end else begin
              tx <= shift[1];
            end
          end
        end
        U_STOP: begin
          if (bit_end) begin
            state <= U_IDLE;
            busy  <= 1'b0;
            done  <= 1'b1;
          end
        end
        default: state <= U_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- list.f
design/ble_pkg.sv
design/uart_byte_if.sv
design/feature_fifo.sv
design/uart_tick_generator.sv
design/uart_tx.sv
design/uart_rx.sv
design/bluetooth.sv
design/ble_link_top.sv
verif/ble_link_checker.sv
verif/tb_ble_link.sv

//--- run.sh
#!/bin/sh
# Build and run the BLE link testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_ble_link -f list.f -Mdir obj_dir -o sim_ble_link \
  && ./obj_dir/sim_ble_link > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

//--- verif/ble_link_checker.sv
`default_nettype none

module ble_link_checker (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic [15:0] feature_data,
  input  logic        feature_valid,
  input  logic        feature_ready,
  input  logic        uart_cts_in,
  input  logic        uart_tx_out,
  input  logic [15:0] param_data,
  input  logic [7:0]  param_addr,
  input  logic        param_valid,
  input  logic [7:0]  rx_byte,
  input  logic        rx_byte_good,
  input  logic        rx_byte_strobe,
  output int          error_count,
  output int          tx_pending,
  output int          param_pending
);

  import ble_pkg::*;

  localparam int bit_clks = int'(tick_div * sample_rate);
  localparam int half_bit = bit_clks / 2;
  // Clocks from a cts-low cycle to the start bit it allows
  localparam int cts_window = 8;

  logic [7:0]  tx_model [$];
  logic [15:0] param_model [$];
  logic [7:0]  rx_low;
  logic        rx_have_low;
  logic [7:0]  next_addr;
  logic [7:0]  frame_byte;
  logic [7:0]  exp_byte;
  logic [15:0] exp_word;
  logic        line_prev;
  logic        in_frame;
  int          frame_cnt;
  int          bit_no;
  int          cts_low_age;
  int          rst_cycles;
  int          post_rst;

  initial begin
    error_count   = 0;
    tx_pending    = 0;
    param_pending = 0;
    rx_low        = '0;
    rx_have_low   = 1'b0;
    next_addr     = '0;
    frame_byte    = '0;
    line_prev     = 1'b1;
    in_frame      = 1'b0;
    frame_cnt     = 0;
    cts_low_age   = 0;
    rst_cycles    = 0;
    post_rst      = 0;
  end

  task automatic log_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic check_idle_state(input string when);
    if (uart_tx_out !== 1'b1) log_error($sformatf("tx_out is %b %s", uart_tx_out, when));
    if (feature_ready !== 1'b1) log_error($sformatf("feature_ready is %b %s", feature_ready, when));
    if (param_valid !== 1'b0) log_error($sformatf("param_valid is %b %s", param_valid, when));
  endtask

  // All sampling on the falling edge, half a clock away from any change
  always @(negedge clk_in) begin
    if (rst_in) begin
      if (rst_cycles > 0) check_idle_state("during reset");
      rst_cycles++;
      post_rst = 0;
    end else begin
      if (rst_cycles > 0 && post_rst < 4) begin
        check_idle_state("after reset");
        post_rst++;
      end

      ////////////////////////////////////////////////////////////
      // Models
      ////////////////////////////////////////////////////////////

      // Word transfers on the next rising edge, low byte goes first
      if (feature_valid && feature_ready) begin
        tx_model.push_back(feature_data[7:0]);
        tx_model.push_back(feature_data[15:8]);
      end

      // Dropped frames leave the pairing untouched
      if (rx_byte_strobe && rx_byte_good) begin
        if (rx_have_low) begin
          param_model.push_back({rx_byte, rx_low});
          rx_have_low = 1'b0;
        end else begin
          rx_low      = rx_byte;
          rx_have_low = 1'b1;
        end
      end

      if (param_valid) begin
        if (param_model.size() == 0) begin
          log_error($sformatf("param_valid with data %04h and no word expected", param_data));
        end else begin
          exp_word = param_model.pop_front();
          if (param_data !== exp_word || param_addr !== next_addr) begin
            log_error($sformatf("param got %04h at %0d, expected %04h at %0d",
                                param_data, param_addr, exp_word, next_addr));
          end
        end
        next_addr = next_addr + 8'd1;
      end

      ////////////////////////////////////////////////////////////
      // Transmit line decoder
      ////////////////////////////////////////////////////////////

      if (!in_frame) begin
        if (line_prev && !uart_tx_out) begin
          in_frame  = 1'b1;
          frame_cnt = 0;
          if (cts_low_age > cts_window) begin
            log_error($sformatf("start bit with cts high for %0d clocks", cts_low_age));
          end
        end
      end else begin
        frame_cnt++;
        if (frame_cnt >= half_bit && (frame_cnt - half_bit) % bit_clks == 0) begin
          bit_no = (frame_cnt - half_bit) / bit_clks;
          if (bit_no == 0) begin
            if (uart_tx_out !== 1'b0) log_error("start bit not low at mid-bit");
          end else if (bit_no <= 8) begin
            frame_byte = {uart_tx_out, frame_byte[7:1]};
          end else begin
            if (uart_tx_out !== 1'b1) log_error("stop bit not high at mid-bit");
            if (tx_model.size() == 0) begin
              log_error($sformatf("tx byte %02h sent with no word accepted", frame_byte));
            end else begin
              exp_byte = tx_model.pop_front();
              if (frame_byte !== exp_byte) begin
                log_error($sformatf("tx byte got %02h expected %02h", frame_byte, exp_byte));
              end
            end
            in_frame = 1'b0;
          end
        end
      end
    end

    if (!uart_cts_in) begin
      cts_low_age = 0;
    end else if (cts_low_age < 100000) begin
      cts_low_age++;
    end
    line_prev     = uart_tx_out;
    tx_pending    = tx_model.size();
    param_pending = param_model.size();
  end

endmodule

`default_nettype wire

//--- verif/tb_ble_link.sv
`default_nettype none

module tb_ble_link;

  import ble_pkg::*;

  localparam int bit_clks      = int'(tick_div * sample_rate);
  localparam int word_count    = 40;
  localparam int rx_byte_count = 24;
  // Bad frame lands between the two bytes of a pair
  localparam int bad_after     = 7;

  logic        clk_in;
  logic        rst_in;
  logic [15:0] feature_data;
  logic        feature_valid;
  logic        feature_ready;
  logic        uart_rx_in;
  logic        uart_cts_in;
  logic        uart_tx_out;
  logic [15:0] param_data;
  logic [7:0]  param_addr;
  logic        param_valid;
  logic [7:0]  rx_byte;
  logic        rx_byte_good;
  logic        rx_byte_strobe;
  int          chk_errors;
  int          tx_pending;
  int          param_pending;
  integer      seed;
  int          stim_errors;
  int          timeouts;
  logic        abort;
  logic        words_done;
  logic        bytes_done;

  ble_link_top dut (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .feature_data  (feature_data),
    .feature_valid (feature_valid),
    .feature_ready (feature_ready),
    .uart_rx_in    (uart_rx_in),
    .uart_cts_in   (uart_cts_in),
    .uart_tx_out   (uart_tx_out),
    .param_data    (param_data),
    .param_addr    (param_addr),
    .param_valid   (param_valid)
  );

  ble_link_checker chk (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .feature_data   (feature_data),
    .feature_valid  (feature_valid),
    .feature_ready  (feature_ready),
    .uart_cts_in    (uart_cts_in),
    .uart_tx_out    (uart_tx_out),
    .param_data     (param_data),
    .param_addr     (param_addr),
    .param_valid    (param_valid),
    .rx_byte        (rx_byte),
    .rx_byte_good   (rx_byte_good),
    .rx_byte_strobe (rx_byte_strobe),
    .error_count    (chk_errors),
    .tx_pending     (tx_pending),
    .param_pending  (param_pending)
  );

  always #10 clk_in = ~clk_in;

  function automatic int pick(input int limit);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % limit);
  endfunction

  function automatic logic [15:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  function automatic logic [7:0] random_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // Inputs change 2 time units after the rising edge
  task automatic wait_clocks(input int n);
    repeat (n) begin
      @(posedge clk_in);
      #2;
    end
  endtask

  task automatic send_word(input logic [15:0] data);
    int   n;
    logic taken;
    n             = 0;
    taken         = 1'b0;
    feature_data  = data;
    feature_valid = 1'b1;
    while (!taken && n < 1000) begin
      @(negedge clk_in);
      taken = feature_ready;
      @(posedge clk_in);
      #2;
      n++;
    end
    feature_valid = 1'b0;
    if (!taken) begin
      $display("Timeout: feature word %04h was never accepted", data);
      timeouts++;
      abort = 1'b1;
    end
  endtask

  // 8N1 frame on the receive line with a low stop bit when good is 0
  task automatic drive_uart_byte(input logic [7:0] data, input logic good);
    int b;
    rx_byte        = data;
    rx_byte_good   = good;
    rx_byte_strobe = 1'b1;
    uart_rx_in     = 1'b0;
    wait_clocks(1);
    rx_byte_strobe = 1'b0;
    wait_clocks(bit_clks - 1);
    for (b = 0; b < 8; b++) begin
      uart_rx_in = data[b];
      wait_clocks(bit_clks);
    end
    uart_rx_in = good;
    wait_clocks(bit_clks);
    uart_rx_in = 1'b1;
    // Line must rest high so the next start bit has an edge
    if (!good) wait_clocks(2 * bit_clks);
  endtask

  task automatic wait_for_drain(input int limit, input string what);
    int n;
    n = 0;
    while ((tx_pending != 0 || param_pending != 0 || uart_tx_out !== 1'b1) && n < limit) begin
      wait_clocks(1);
      n++;
    end
    if (tx_pending != 0 || param_pending != 0 || uart_tx_out !== 1'b1) begin
      $display("Timeout: %s did not drain, %0d bytes and %0d parameter words still expected",
               what, tx_pending, param_pending);
      timeouts++;
      abort = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Back-pressure with cts held high
  ////////////////////////////////////////////////////////////

  task automatic fill_fifo();
    int   accepted;
    int   n;
    int   k;
    logic full;
    accepted      = 0;
    n             = 0;
    full          = 1'b0;
    uart_cts_in   = 1'b1;
    wait_clocks(bit_clks);
    feature_data  = rand_word();
    feature_valid = 1'b1;
    while (!full && n < 2 * fifo_depth) begin
      @(negedge clk_in);
      if (feature_ready) accepted++;
      else full = 1'b1;
      @(posedge clk_in);
      #2;
      if (!full) feature_data = rand_word();
      n++;
    end
    if (!full) begin
      $display("Timeout: feature_ready never dropped with cts held high");
      timeouts++;
      abort = 1'b1;
    end else if (accepted != fifo_depth + 1) begin
      // One word leaves the FIFO and waits in the controller for cts
      $display("[ERROR] %0t: FIFO full after %0d words, expected %0d",
               $time, accepted, fifo_depth + 1);
      stim_errors++;
    end
    // Long enough for a whole word to leave if cts were ignored
    for (k = 0; k < 3 * 10 * bit_clks; k++) begin
      @(negedge clk_in);
      if (feature_ready) begin
        $display("[ERROR] %0t: feature_ready rose while cts was held high", $time);
        stim_errors++;
      end
      @(posedge clk_in);
      #2;
    end
    feature_valid = 1'b0;
    uart_cts_in   = 1'b0;
  endtask

  initial begin
    int i;
    int j;
    int holds;
    seed           = 32'hb88f_8d55;
    clk_in         = 1'b0;
    rst_in         = 1'b1;
    feature_data   = '0;
    feature_valid  = 1'b0;
    uart_rx_in     = 1'b1;
    uart_cts_in    = 1'b0;
    rx_byte        = '0;
    rx_byte_good   = 1'b0;
    rx_byte_strobe = 1'b0;
    stim_errors    = 0;
    timeouts       = 0;
    abort          = 1'b0;
    words_done     = 1'b0;
    bytes_done     = 1'b0;
    repeat (8) @(posedge clk_in);
    #2;
    rst_in = 1'b0;
    wait_clocks(4);

    fork
      begin
        for (i = 0; i < word_count && !abort; i++) begin
          wait_clocks(pick(6));
          send_word(rand_word());
        end
        words_done = 1'b1;
      end
      begin
        for (j = 0; j < rx_byte_count; j++) begin
          if (j == bad_after) drive_uart_byte(random_byte(), 1'b0);
          drive_uart_byte(random_byte(), 1'b1);
          wait_clocks(pick(3) * bit_clks);
        end
        bytes_done = 1'b1;
      end
      begin
        holds = 0;
        while (!(words_done && bytes_done) && holds < 500) begin
          uart_cts_in = 1'b1;
          wait_clocks(100 + pick(300));
          uart_cts_in = 1'b0;
          wait_clocks(200 + pick(400));
          holds++;
        end
        uart_cts_in = 1'b0;
      end
    join

    if (!abort) wait_for_drain(200000, "random traffic");
    if (!abort) begin
      wait_clocks(2 * bit_clks);
      fill_fifo();
    end
    if (!abort) wait_for_drain(600000, "full FIFO");

    $display("Errors: checker %0d, stimulus %0d, timeouts %0d",
             chk_errors, stim_errors, timeouts);
    if (chk_errors == 0 && stim_errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
